//--- project.f
src/shader_types_pkg.sv
src/shader_tables_pkg.sv
src/normal_unit.sv
src/magnitude_unit.sv
src/angle_search.sv
src/shade_lookup.sv
src/pixel_shader.sv
tests/shade_checker.sv
tests/tb_pixel_shader.sv

//--- run_sim.sh
#!/bin/sh
# build and run the pixel shader testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -Wno-fatal -f project.f \
    --top-module tb_pixel_shader -o sim_pixel_shader || exit 1
out=$(./obj_dir/sim_pixel_shader)
echo "$out"
echo "$out" | grep -qx "sim passed" && exit 0 || exit 1

//--- src/angle_search.sv
`timescale 1ns/1ps
`default_nettype none

module angle_search
    import shader_types_pkg::*;
    import shader_tables_pkg::*;
(
    input wire logic clk_in,
    input wire logic rst_in,
    input wire logic valid_in,
    input wire mag_t mag,
    input wire square_t nz_square,
    input wire logic nz_positive_in,
    output logic valid_out,
    output bucket_t bucket,
    output logic nz_positive
);

    // operands plus the partial bucket
    typedef struct packed {
        mag_t mag;
        square_t nz_sq;
        logic nz_pos;
        bucket_t acc;
    } search_t;

    // mag / nz^2 >= sec^2(k), done by cross-multiplying
    function automatic logic passes(mag_t m, square_t nz_sq, bucket_t k);
        logic [63:0] lhs;
        logic [63:0] rhs;
        sec2_t thr;
        // entries past the table never pass
        if (k >= bucket_t'(NUM_THRESHOLDS)) begin
            return 1'b0;
        end
        thr = sec2_thresholds[k];
        lhs = 64'(m) << SEC2_FRAC_BITS;
        rhs = 64'(nz_sq) * 64'(thr);
        return lhs >= rhs;
    endfunction

    // one halving step per stage, msb of the bucket first
    for (genvar s = 0; s < SEARCH_LATENCY; s++) begin : g_step
        search_t cur;
        logic cur_valid;
        bucket_t probe;
        search_t step_q;
        logic valid_q;

        if (s == 0) begin : g_first
            assign cur = '{mag: mag, nz_sq: nz_square, nz_pos: nz_positive_in, acc: '0};
            assign cur_valid = valid_in;
        end else begin : g_next
            assign cur = g_step[s-1].step_q;
            assign cur_valid = g_step[s-1].valid_q;
        end

        // candidate count, keep it if threshold probe-1 is passed
        assign probe = cur.acc | bucket_t'(1 << (BUCKET_W - 1 - s));

        always_ff @(posedge clk_in) begin
            if (rst_in) begin
                valid_q <= 1'b0;
            end else begin
                valid_q <= cur_valid;
            end
        end

        always_ff @(posedge clk_in) begin
            step_q <= cur;
            if (passes(cur.mag, cur.nz_sq, probe - bucket_t'(1))) begin
                step_q.acc <= probe;
            end
        end
    end

    assign valid_out = g_step[SEARCH_LATENCY-1].valid_q;
    assign bucket = g_step[SEARCH_LATENCY-1].step_q.acc;
    assign nz_positive = g_step[SEARCH_LATENCY-1].step_q.nz_pos;

    // count over the whole table tops out at nine
    a_bucket_range: assert property (
        @(posedge clk_in) disable iff (rst_in)
        valid_out |-> (bucket <= bucket_t'(NUM_THRESHOLDS))
    ) else $error("angle_search bucket %0d out of range", bucket);

endmodule

`default_nettype wire

//--- src/magnitude_unit.sv
`timescale 1ns/1ps
`default_nettype none

module magnitude_unit
    import shader_types_pkg::*;
(
    input wire logic clk_in,
    input wire logic rst_in,
    input wire logic valid_in,
    input wire normal_t normal,
    output logic valid_out,
    output mag_t mag,
    output square_t nz_square,
    output logic nz_positive
);

    typedef struct packed {
        square_t nx_sq;
        square_t ny_sq;
        square_t nz_sq;
        logic nz_pos;
    } squares_t;

    squares_t squares_q;
    logic squares_valid_q;

    // exact square, sign extended before the multiply
    function automatic square_t square_of(normal_comp_t n);
        logic signed [SQUARE_W:0] wide;
        wide = n * n;
        return square_t'(wide);
    endfunction

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            squares_valid_q <= 1'b0;
            valid_out <= 1'b0;
        end else begin
            squares_valid_q <= valid_in;
            valid_out <= squares_valid_q;
        end
    end

    always_ff @(posedge clk_in) begin
        // stage 1
        squares_q.nx_sq <= square_of(normal.nx);
        squares_q.ny_sq <= square_of(normal.ny);
        squares_q.nz_sq <= square_of(normal.nz);
        // strictly positive, zero counts as facing
        squares_q.nz_pos <= !normal.nz[NORMAL_W-1] && (normal.nz != '0);
        // stage 2, sum of three squares
        mag <= mag_t'(squares_q.nx_sq) + mag_t'(squares_q.ny_sq)
               + mag_t'(squares_q.nz_sq);
        // nz terms ride along for the search
        nz_square <= squares_q.nz_sq;
        nz_positive <= squares_q.nz_pos;
    end

endmodule

`default_nettype wire

//--- src/normal_unit.sv
`timescale 1ns/1ps
`default_nettype none

module normal_unit
    import shader_types_pkg::*;
    import shader_tables_pkg::*;
(
    input wire logic clk_in,
    input wire logic rst_in,
    input wire logic valid_in,
    input wire triangle_t triangle,
    output logic valid_out,
    output normal_t normal
);

    typedef struct packed {
        edge_t x;
        edge_t y;
        edge_t z;
    } edge_vec_t;

    // u = v1 - v0, w = v2 - v0
    typedef struct packed {
        edge_vec_t u;
        edge_vec_t w;
    } edges_t;

    // the six cross-product terms
    typedef struct packed {
        product_t uy_wz;
        product_t uz_wy;
        product_t uz_wx;
        product_t ux_wz;
        product_t ux_wy;
        product_t uy_wx;
    } products_t;

    edges_t edges_q;
    products_t products_q;
    logic edges_valid_q;
    logic products_valid_q;

    // valid chain, cleared by reset
    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            edges_valid_q <= 1'b0;
            products_valid_q <= 1'b0;
            valid_out <= 1'b0;
        end else begin
            edges_valid_q <= valid_in;
            products_valid_q <= edges_valid_q;
            valid_out <= products_valid_q;
        end
    end

    always_ff @(posedge clk_in) begin
        // stage 1, edges widen to 9 bits
        edges_q.u.x <= triangle.v1.x - triangle.v0.x;
        edges_q.u.y <= triangle.v1.y - triangle.v0.y;
        edges_q.u.z <= triangle.v1.z - triangle.v0.z;
        edges_q.w.x <= triangle.v2.x - triangle.v0.x;
        edges_q.w.y <= triangle.v2.y - triangle.v0.y;
        edges_q.w.z <= triangle.v2.z - triangle.v0.z;
        // stage 2, signed products
        products_q.uy_wz <= edges_q.u.y * edges_q.w.z;
        products_q.uz_wy <= edges_q.u.z * edges_q.w.y;
        products_q.uz_wx <= edges_q.u.z * edges_q.w.x;
        products_q.ux_wz <= edges_q.u.x * edges_q.w.z;
        products_q.ux_wy <= edges_q.u.x * edges_q.w.y;
        products_q.uy_wx <= edges_q.u.y * edges_q.w.x;
        // stage 3, cross product u x w
        normal.nx <= products_q.uy_wz - products_q.uz_wy;
        normal.ny <= products_q.uz_wx - products_q.ux_wz;
        normal.nz <= products_q.ux_wy - products_q.uy_wx;
    end

    // output valid trails input valid by the full unit depth
    a_valid_delay: assert property (
        @(posedge clk_in) disable iff (rst_in)
        (!$past(rst_in, 1) && !$past(rst_in, 2) && !$past(rst_in, 3))
            |-> (valid_out == $past(valid_in, NORMAL_LATENCY))
    ) else $error("normal_unit valid_out out of step with valid_in");

endmodule

`default_nettype wire

//--- src/pixel_shader.sv
`timescale 1ns/1ps
`default_nettype none

module pixel_shader
    import shader_types_pkg::*;
(
    input wire logic clk_in,
    input wire logic rst_in,
    input wire logic data_valid_in,
    input wire triangle_t triangle,
    output logic valid_out,
    output grey_t color_out
);

    // normal stage outputs
    logic normal_valid;
    normal_t normal;
    // magnitude stage outputs
    logic mag_valid;
    mag_t mag;
    square_t nz_square;
    logic mag_nz_positive;
    // search stage outputs
    logic search_valid;
    bucket_t bucket;
    logic search_nz_positive;

    normal_unit u_normal (
        .clk_in(clk_in),
        .rst_in(rst_in),
        .valid_in(data_valid_in),
        .triangle(triangle),
        .valid_out(normal_valid),
        .normal(normal)
    );

    magnitude_unit u_magnitude (
        .clk_in(clk_in),
        .rst_in(rst_in),
        .valid_in(normal_valid),
        .normal(normal),
        .valid_out(mag_valid),
        .mag(mag),
        .nz_square(nz_square),
        .nz_positive(mag_nz_positive)
    );

    angle_search u_search (
        .clk_in(clk_in),
        .rst_in(rst_in),
        .valid_in(mag_valid),
        .mag(mag),
        .nz_square(nz_square),
        .nz_positive_in(mag_nz_positive),
        .valid_out(search_valid),
        .bucket(bucket),
        .nz_positive(search_nz_positive)
    );

    // last stage drives the ports directly
    shade_lookup u_shade (
        .clk_in(clk_in),
        .rst_in(rst_in),
        .valid_in(search_valid),
        .bucket(bucket),
        .nz_positive(search_nz_positive),
        .valid_out(valid_out),
        .color(color_out)
    );

endmodule

`default_nettype wire

//--- src/shade_lookup.sv
`timescale 1ns/1ps
`default_nettype none

module shade_lookup
    import shader_types_pkg::*;
    import shader_tables_pkg::*;
(
    input wire logic clk_in,
    input wire logic rst_in,
    input wire logic valid_in,
    input wire bucket_t bucket,
    input wire logic nz_positive,
    output logic valid_out,
    output grey_t color
);

    shade_index_t index;

    // nz > 0 points away from the light at (0, 0, -1)
    always_comb begin
        if (nz_positive) begin
            index = shade_index_t'(SHADE_MAX_INDEX) - shade_index_t'(bucket);
        end else begin
            index = shade_index_t'(bucket);
        end
    end

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            valid_out <= 1'b0;
        end else begin
            valid_out <= valid_in;
        end
    end

    // grey level for the folded angle
    always_ff @(posedge clk_in) begin
        color <= grey_table[index];
    end

    // folded index lands in the half of the table that matches the facing side
    a_index_range: assert property (
        @(posedge clk_in) disable iff (rst_in)
        valid_in |-> (nz_positive
                      ? (index >= shade_index_t'(NUM_THRESHOLDS)
                         && index <= shade_index_t'(SHADE_MAX_INDEX))
                      : (index <= shade_index_t'(NUM_THRESHOLDS)))
    ) else $error("shade_lookup index %0d outside its half of the table", index);

endmodule

`default_nettype wire

//--- src/shader_tables_pkg.sv
`default_nettype none

package shader_tables_pkg;

    // thresholds are Q16 fixed point
    localparam int SEC2_FRAC_BITS = 16;
    // bucket edges at 5, 15, ... 85 degrees
    localparam int NUM_THRESHOLDS = 9;
    // 8.6e6 at 85 degrees fits in 24 bits
    localparam int SEC2_W = 24;

    typedef logic [SEC2_W-1:0] sec2_t;

    // round(65536 / cos^2(theta)), theta = 5 + 10k degrees
    localparam sec2_t sec2_thresholds [NUM_THRESHOLDS] = '{
        24'd66038,
        24'd70241,
        24'd79786,
        24'd97668,
        24'd131072,
        24'd199204,
        24'd366930,
        24'd978335,
        24'd8627559
    };

    // 0 to 180 degrees in 10 degree steps
    localparam int NUM_SHADE_LEVELS = 19;
    localparam int SHADE_MAX_INDEX = NUM_SHADE_LEVELS - 1;

    // light falls off steeply toward edge-on, 30 matches 20
    localparam shader_types_pkg::grey_t grey_table [NUM_SHADE_LEVELS] = '{
        8'd255,
        8'd254,
        8'd236,
        8'd236,
        8'd200,
        8'd140,
        8'd75,
        8'd40,
        8'd20,
        8'd0,
        8'd20,
        8'd40,
        8'd75,
        8'd140,
        8'd200,
        8'd236,
        8'd252,
        8'd255,
        8'd255
    };

    // per-unit register stages
    localparam int NORMAL_LATENCY = 3;
    localparam int MAG_LATENCY = 2;
    localparam int SEARCH_LATENCY = 4;
    localparam int SHADE_LATENCY = 1;
    localparam int SHADER_LATENCY = NORMAL_LATENCY + MAG_LATENCY + SEARCH_LATENCY
                                    + SHADE_LATENCY;

endpackage

`default_nettype wire

//--- src/shader_types_pkg.sv
`default_nettype none

package shader_types_pkg;

    // vertex coordinates, signed 8-bit
    localparam int COORD_W = 8;
    // difference of two coordinates needs one more bit
    localparam int EDGE_W = COORD_W + 1;
    // product of two edge components
    localparam int PRODUCT_W = 2 * EDGE_W;
    // difference of two products
    localparam int NORMAL_W = PRODUCT_W + 1;
    // square of a normal component, kept with headroom
    localparam int SQUARE_W = 2 * NORMAL_W - 1;
    // sum of three squares
    localparam int MAG_W = SQUARE_W + 2;
    // angle bucket 0..9, 10 degree steps
    localparam int BUCKET_W = 4;
    // folded angle index 0..18
    localparam int SHADE_INDEX_W = 5;
    localparam int GREY_W = 8;

    typedef logic signed [COORD_W-1:0] coord_t;
    typedef logic signed [EDGE_W-1:0] edge_t;
    typedef logic signed [PRODUCT_W-1:0] product_t;
    typedef logic signed [NORMAL_W-1:0] normal_comp_t;
    typedef logic [SQUARE_W-1:0] square_t;
    typedef logic [MAG_W-1:0] mag_t;
    typedef logic [BUCKET_W-1:0] bucket_t;
    typedef logic [SHADE_INDEX_W-1:0] shade_index_t;
    typedef logic [GREY_W-1:0] grey_t;

    // one vertex, x in the top bits
    typedef struct packed {
        coord_t x;
        coord_t y;
        coord_t z;
    } vertex_t;

    // v0 is the origin of both edge vectors
    typedef struct packed {
        vertex_t v0;
        vertex_t v1;
        vertex_t v2;
    } triangle_t;

    // surface normal, exact integer
    typedef struct packed {
        normal_comp_t nx;
        normal_comp_t ny;
        normal_comp_t nz;
    } normal_t;

endpackage

`default_nettype wire

//--- tests/shade_checker.sv
`timescale 1ns/1ps
`default_nettype none

module shade_checker
    import shader_types_pkg::*;
    import shader_tables_pkg::*;
(
    input wire logic clk_in,
    input wire logic rst_in,
    input wire logic data_valid_in,
    input wire triangle_t triangle,
    input wire logic valid_out,
    input wire grey_t color_out
);

    // one result still inside the pipeline
    typedef struct packed {
        grey_t color;
        int due_cycle;
    } expected_t;

    expected_t expected_q[$];
    expected_t head;
    expected_t fresh;
    int shade_index;
    int cycle_count = 0;
    // running totals for the testbench top
    int accepted_count = 0;
    int resolved_count = 0;
    int output_count = 0;
    int error_count = 0;
    int zero_count = 0;
    int near_count = 0;
    int far_count = 0;

    // folded angle index 0..18 straight from the geometry
    function automatic int model_index(input triangle_t t);
        longint ux, uy, uz;
        longint wx, wy, wz;
        longint nx, ny, nz;
        longint mag;
        longint nz_sq;
        int count;
        ux = longint'(t.v1.x) - longint'(t.v0.x);
        uy = longint'(t.v1.y) - longint'(t.v0.y);
        uz = longint'(t.v1.z) - longint'(t.v0.z);
        wx = longint'(t.v2.x) - longint'(t.v0.x);
        wy = longint'(t.v2.y) - longint'(t.v0.y);
        wz = longint'(t.v2.z) - longint'(t.v0.z);
        // u x w
        nx = uy * wz - uz * wy;
        ny = uz * wx - ux * wz;
        nz = ux * wy - uy * wx;
        mag = nx * nx + ny * ny + nz * nz;
        nz_sq = nz * nz;
        // plain linear count of passed thresholds
        count = 0;
        for (int k = 0; k < NUM_THRESHOLDS; k++) begin
            if (mag * (longint'(1) << SEC2_FRAC_BITS)
                    >= nz_sq * longint'(sec2_thresholds[k])) begin
                count++;
            end
        end
        // normal pointing away from the light at (0, 0, -1)
        if (nz > 0) begin
            return 18 - count;
        end
        return count;
    endfunction

    // inputs are stable at the rising edge
    always @(posedge clk_in) begin
        cycle_count = cycle_count + 1;
        if (!rst_in && data_valid_in === 1'b1) begin
            shade_index = model_index(triangle);
            fresh.color = grey_table[shade_index];
            fresh.due_cycle = cycle_count + SHADER_LATENCY;
            expected_q.push_back(fresh);
            accepted_count++;
            if (shade_index > 9) begin
                far_count++;
            end else if (shade_index < 9) begin
                near_count++;
            end
        end
    end

    // a result seen half a cycle after an edge is sampled by the next edge
    always @(negedge clk_in) begin
        if (valid_out !== 1'b0) begin
            if (expected_q.size() == 0) begin
                $display("valid_out not low at cycle %0d with no triangle in flight",
                         cycle_count);
                error_count++;
            end else begin
                head = expected_q.pop_front();
                resolved_count++;
                output_count++;
                if (head.due_cycle != cycle_count + 1) begin
                    $display("result came out at cycle %0d but was due at cycle %0d",
                             cycle_count + 1, head.due_cycle);
                    error_count++;
                end
                if (color_out !== head.color) begin
                    $display("Mismatch color_out: got 0x%02h, expected 0x%02h",
                             color_out, head.color);
                    error_count++;
                end
                if (color_out === '0) begin
                    zero_count++;
                end
            end
        end else if (expected_q.size() != 0 && expected_q[0].due_cycle <= cycle_count) begin
            // drop an overdue result so later ones still line up
            head = expected_q.pop_front();
            resolved_count++;
            $display("no result by cycle %0d for the triangle due at cycle %0d",
                     cycle_count + 1, head.due_cycle);
            error_count++;
        end
    end

endmodule

`default_nettype wire

//--- tests/tb_pixel_shader.sv
`timescale 1ns/1ps
`default_nettype none

module tb_pixel_shader
    import shader_types_pkg::*;
    import shader_tables_pkg::*;
();

    localparam int SEED = 39;
    localparam int RESET_CYCLES = 8;
    localparam int IDLE_CYCLES = 20;
    localparam int RANDOM_COUNT = 60;
    localparam int MAX_GAP = 3;
    localparam int BURST_COUNT = 40;
    localparam int DEGEN_COUNT = 12;
    localparam int SWAP_PAIRS = 30;
    localparam int EXTREME_COUNT = 32;
    localparam int NUM_TESTS = 6;
    // every input slot with the longest gaps plus a drain per test and margin
    localparam int INPUT_CYCLES = RANDOM_COUNT * (MAX_GAP + 1) + BURST_COUNT + DEGEN_COUNT
                                  + 2 * SWAP_PAIRS + EXTREME_COUNT;
    localparam int TIMEOUT_CYCLES = RESET_CYCLES + IDLE_CYCLES + INPUT_CYCLES
                                    + NUM_TESTS * (SHADER_LATENCY + 4) + 50;

    logic clk_in = 1'b0;
    logic rst_in;
    logic data_valid_in;
    triangle_t triangle;
    logic valid_out;
    grey_t color_out;
    int cycle_count = 0;
    int tb_errors = 0;
    int tests_failed = 0;
    int error_mark = 0;
    int output_mark = 0;

    pixel_shader uut (
        .clk_in(clk_in),
        .rst_in(rst_in),
        .data_valid_in(data_valid_in),
        .triangle(triangle),
        .valid_out(valid_out),
        .color_out(color_out)
    );

    shade_checker u_check (
        .clk_in(clk_in),
        .rst_in(rst_in),
        .data_valid_in(data_valid_in),
        .triangle(triangle),
        .valid_out(valid_out),
        .color_out(color_out)
    );

    // 20 ns period
    always #10 clk_in = ~clk_in;

    always @(posedge clk_in) begin
        cycle_count = cycle_count + 1;
        if (cycle_count > TIMEOUT_CYCLES) begin
            $display("run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("sim failed");
            $finish;
        end
    end

    function automatic coord_t small_coord(input int span);
        return coord_t'(int'($urandom_range(0, 2 * span)) - span);
    endfunction

    function automatic vertex_t small_vertex(input int span);
        vertex_t v;
        v.x = small_coord(span);
        v.y = small_coord(span);
        v.z = small_coord(span);
        return v;
    endfunction

    function automatic vertex_t add_vertex(input vertex_t a, input vertex_t b);
        vertex_t v;
        v.x = a.x + b.x;
        v.y = a.y + b.y;
        v.z = a.z + b.z;
        return v;
    endfunction

    // any value in the full signed range
    function automatic triangle_t random_triangle();
        triangle_t t;
        t.v0 = small_vertex(128);
        t.v1 = small_vertex(128);
        t.v2 = small_vertex(128);
        return t;
    endfunction

    // mostly the ends of the coordinate range
    function automatic coord_t extreme_coord();
        case ($urandom_range(0, 3))
            0: return coord_t'(-128);
            1: return coord_t'(127);
            2: return coord_t'(-1);
            default: return coord_t'(0);
        endcase
    endfunction

    function automatic triangle_t extreme_triangle();
        triangle_t t;
        t.v0 = '{x: extreme_coord(), y: extreme_coord(), z: extreme_coord()};
        t.v1 = '{x: extreme_coord(), y: extreme_coord(), z: extreme_coord()};
        t.v2 = '{x: extreme_coord(), y: extreme_coord(), z: extreme_coord()};
        return t;
    endfunction

    // kind 0 repeats a vertex, 1 is collinear, 2 is edge-on with one shared y
    function automatic triangle_t degenerate_triangle(input int kind);
        triangle_t t;
        vertex_t step;
        t.v0 = small_vertex(60);
        step = small_vertex(30);
        case (kind)
            0: begin
                t.v1 = t.v0;
                t.v2 = small_vertex(60);
            end
            1: begin
                t.v1 = add_vertex(t.v0, step);
                t.v2 = add_vertex(t.v1, step);
            end
            default: begin
                t.v1 = small_vertex(60);
                t.v2 = small_vertex(60);
                t.v1.y = t.v0.y;
                t.v2.y = t.v0.y;
            end
        endcase
        return t;
    endfunction

    task automatic send(input triangle_t t);
        @(negedge clk_in);
        data_valid_in = 1'b1;
        triangle = t;
    endtask

    task automatic idle(input int n);
        repeat (n) begin
            @(negedge clk_in);
            data_valid_in = 1'b0;
        end
    endtask

    // wait until every accepted triangle has come out
    task automatic drain();
        idle(1);
        while (u_check.accepted_count != u_check.resolved_count) begin
            idle(1);
        end
        idle(2);
    endtask

    task automatic start_test();
        error_mark = u_check.error_count + tb_errors;
        output_mark = u_check.output_count;
    endtask

    task automatic expect_outputs(input int n);
        if (u_check.output_count - output_mark != n) begin
            $display("expected %0d results but saw %0d", n, u_check.output_count - output_mark);
            tb_errors++;
        end
    endtask

    task automatic end_test(input string name);
        int errors;
        errors = u_check.error_count + tb_errors - error_mark;
        if (errors == 0) begin
            $display("test %s ok", name);
        end else begin
            $display("test %s failed with %0d errors", name, errors);
            tests_failed++;
        end
    endtask

    initial begin
        triangle_t t;
        triangle_t swapped;
        int zero_mark;
        int near_mark;
        int far_mark;
        void'($urandom(SEED));
        rst_in = 1'b1;
        data_valid_in = 1'b0;
        triangle = '0;

        // checker flags any stray valid_out during reset and idle
        start_test();
        repeat (RESET_CYCLES) @(negedge clk_in);
        rst_in = 1'b0;
        idle(IDLE_CYCLES);
        expect_outputs(0);
        end_test("reset_idle");

        // random triangles with random gaps
        start_test();
        repeat (RANDOM_COUNT) begin
            send(random_triangle());
            idle($urandom_range(0, MAX_GAP));
        end
        drain();
        expect_outputs(RANDOM_COUNT);
        end_test("random_gaps");

        // one triangle per cycle so results come out back to back
        start_test();
        repeat (BURST_COUNT) send(random_triangle());
        drain();
        expect_outputs(BURST_COUNT);
        end_test("burst");

        // all land on index 9 which is grey 0
        start_test();
        zero_mark = u_check.zero_count;
        for (int i = 0; i < DEGEN_COUNT; i++) begin
            send(degenerate_triangle(i % 3));
        end
        drain();
        expect_outputs(DEGEN_COUNT);
        if (u_check.zero_count - zero_mark != DEGEN_COUNT) begin
            $display("only %0d of %0d degenerate triangles gave grey 0",
                     u_check.zero_count - zero_mark, DEGEN_COUNT);
            tb_errors++;
        end
        end_test("degenerate");

        // reversed winding flips the sign of nz
        start_test();
        near_mark = u_check.near_count;
        far_mark = u_check.far_count;
        repeat (SWAP_PAIRS) begin
            t = random_triangle();
            swapped = t;
            swapped.v1 = t.v2;
            swapped.v2 = t.v1;
            send(t);
            send(swapped);
        end
        drain();
        expect_outputs(2 * SWAP_PAIRS);
        if (u_check.near_count == near_mark || u_check.far_count == far_mark) begin
            $display("swapped pairs did not reach both halves of the grey table");
            tb_errors++;
        end
        end_test("winding_swap");

        // corner coordinates give the widest normals
        start_test();
        repeat (EXTREME_COUNT) send(extreme_triangle());
        drain();
        expect_outputs(EXTREME_COUNT);
        end_test("extreme");

        $display("%0d tests, %0d failed, %0d results checked, %0d errors",
                 NUM_TESTS, tests_failed, u_check.output_count,
                 u_check.error_count + tb_errors);
        if (tests_failed == 0 && u_check.error_count + tb_errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
